// File: sifh_settings.svh
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// sizing of the two-pass time-of-flight peak finder

// tdc timestamp width, twice the bin address width
`define SIFH_NP 10

// bin address width for both passes
`define SIFH_NB 5

// bins per histogram
`define SIFH_BINS (1 << `SIFH_NB)

// bin count width
`define SIFH_CNT_W 6

// count at which a bin saturates
`define SIFH_CNT_MAX ((1 << `SIFH_CNT_W) - 1)

// hits taken per pass
`define SIFH_HITS 64

`endif

// File: sifhPkg.sv
`include "sifh_settings.svh"

package sifhPkg;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        CLEAR  = 3'd1,
        BUILD  = 3'd2,
        FIND   = 3'd3,
        FILTER = 3'd4,
        DONE   = 3'd5
    } seqStateT;

    typedef enum logic {
        COARSE = 1'b0, // bin from upper stamp bits
        FINE   = 1'b1  // bin from lower stamp bits, windowed
    } passT;

    typedef struct packed {
        logic                valid;
        logic [`SIFH_NP-1:0] stamp;
    } tdcHitT;

    typedef struct packed {
        logic                   en;
        logic [`SIFH_NB-1:0]    addr;
        logic [`SIFH_CNT_W-1:0] data;
    } ramWrT;

    typedef struct packed {
        logic                en;
        logic [`SIFH_NB-1:0] addr;
    } ramRdT;

    typedef struct packed {
        logic [`SIFH_NB-1:0]    bin;
        logic [`SIFH_CNT_W-1:0] count;
    } peakT;

endpackage

// File: binCounter.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module binCounter (
    input  logic                clk,
    input  logic                res,
    input  logic                countClear,
    input  logic                sweepEn,
    input  logic                hitAccept,
    output logic [`SIFH_NB-1:0] index,
    output logic                sweepLast,
    output logic                hitsDone
);

    localparam int hitW = $clog2(`SIFH_HITS);

    logic [hitW-1:0] hitCount;

    assign sweepLast = sweepEn && (index == `SIFH_NB'(`SIFH_BINS - 1));

    // sweep index wraps back to zero after the last bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            index <= '0;
        end else if (countClear) begin
            index <= '0;
        end else if (sweepEn) begin
            index <= index + 1'b1;
        end
    end

    // accepted hits per pass, dropped fine-pass hits included
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hitCount <= '0;
            hitsDone <= 1'b0;
        end else if (countClear) begin
            hitCount <= '0;
            hitsDone <= 1'b0;
        end else if (hitAccept && !hitsDone) begin
            hitCount <= hitCount + 1'b1;
            if (hitCount == hitW'(`SIFH_HITS - 1)) begin
                hitsDone <= 1'b1; // held until the next pass
            end
        end
    end

endmodule

// File: histRam.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module histRam (
    input  logic                   clk,
    input  sifhPkg::ramWrT         wr,
    input  sifhPkg::ramRdT         rd,
    output logic [`SIFH_CNT_W-1:0] rdData
);

    logic [`SIFH_CNT_W-1:0] mem [`SIFH_BINS];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, same-address write gives old data
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

// File: histAccumulator.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module histAccumulator (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   enable,
    input  sifhPkg::passT          pass,
    input  logic [`SIFH_NB-1:0]    window,
    input  sifhPkg::tdcHitT        hit,
    input  logic [`SIFH_CNT_W-1:0] rdData,
    output sifhPkg::ramRdT         rd,
    output sifhPkg::ramWrT         wr,
    output logic                   hitAccept,
    output logic                   pipeEmpty
);
    import sifhPkg::*;

    logic [`SIFH_NB-1:0]    coarseBin;
    logic [`SIFH_NB-1:0]    fineBin;
    logic [`SIFH_NB-1:0]    hitBin;
    logic                   keep;
    logic                   s1Valid;   // read data arrives this cycle
    logic [`SIFH_NB-1:0]    s1Addr;
    logic                   wrEn;      // write issued on the coming edge
    logic [`SIFH_NB-1:0]    wrAddr;
    logic [`SIFH_CNT_W-1:0] wrData;
    logic                   lastEn;    // write that landed on the last edge
    logic [`SIFH_NB-1:0]    lastAddr;
    logic [`SIFH_CNT_W-1:0] lastData;
    logic [`SIFH_CNT_W-1:0] base;
    logic [`SIFH_CNT_W-1:0] incr;

    assign coarseBin = hit.stamp[`SIFH_NP-1 -: `SIFH_NB];
    assign fineBin   = hit.stamp[`SIFH_NB-1:0];
    assign hitBin    = (pass == COARSE) ? coarseBin : fineBin;
    assign hitAccept = enable && hit.valid;
    assign keep      = hitAccept && ((pass == COARSE) || (coarseBin == window));

    assign rd        = '{en: keep, addr: hitBin};
    assign wr        = '{en: wrEn, addr: wrAddr, data: wrData};
    assign pipeEmpty = !s1Valid && !wrEn;

    // newest in-flight value wins over the ram data
    always_comb begin
        if (wrEn && (wrAddr == s1Addr)) begin
            base = wrData;
        end else if (lastEn && (lastAddr == s1Addr)) begin
            base = lastData;
        end else begin
            base = rdData;
        end
    end

    assign incr = (base == `SIFH_CNT_W'(`SIFH_CNT_MAX)) ? base : base + 1'b1; // saturate

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            wrEn    <= 1'b0;
            lastEn  <= 1'b0;
        end else begin
            s1Valid <= keep;
            wrEn    <= s1Valid;
            lastEn  <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr   <= hitBin;
        wrAddr   <= s1Addr;
        wrData   <= incr;
        lastAddr <= wrAddr;
        lastData <= wrData;
    end

endmodule

// File: peakFinder.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module peakFinder (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   clear,
    input  logic                   sweepEn,
    input  logic [`SIFH_NB-1:0]    index,
    input  logic [`SIFH_CNT_W-1:0] rdData,
    output sifhPkg::ramRdT         rd,
    output sifhPkg::peakT          peak
);

    logic                rdValid; // rdData belongs to rdIndex
    logic [`SIFH_NB-1:0] rdIndex;
    logic                better;

    assign rd = '{en: sweepEn, addr: index};

    // strictly greater, so the lowest bin keeps a tie
    assign better = rdValid && (rdData > peak.count);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= sweepEn;
        end
    end

    always_ff @(posedge clk) begin
        rdIndex <= index; // lines up with the registered read
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
        end else if (clear) begin
            peak <= '0;
        end else if (better) begin
            peak <= '{bin: rdIndex, count: rdData};
        end
    end

endmodule

// File: sifhSequencer.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module sifhSequencer (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  logic                   sweepLast,
    input  logic                   hitsDone,
    input  logic                   pipeEmpty,
    input  sifhPkg::peakT          peakIn,
    output sifhPkg::seqStateT      state,
    output sifhPkg::passT          pass,
    output logic [`SIFH_NB-1:0]    window,
    output logic                   sweepEn,
    output logic                   countClear,
    output logic                   acquire,
    output logic                   busy,
    output logic                   done,
    output logic [`SIFH_NP-1:0]    peakTime,
    output logic [`SIFH_CNT_W-1:0] peakCount
);
    import sifhPkg::*;

    seqStateT   nextState;
    logic [1:0] findTail; // end of read sweep, delayed for ram latency and compare

    assign busy       = (state != IDLE);
    assign done       = (state == DONE);
    assign acquire    = (state == BUILD) && !hitsDone; // high through the last accepted hit
    assign countClear = (state == IDLE) || (state == FILTER); // before each pass
    assign sweepEn    = (state == CLEAR) || ((state == FIND) && (findTail == 2'b00));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                if (sweepLast) begin
                    nextState = BUILD;
                end
            end
            BUILD: begin
                if (hitsDone && pipeEmpty) begin // last write has landed
                    nextState = FIND;
                end
            end
            FIND: begin
                if (findTail[1]) begin
                    nextState = (pass == COARSE) ? FILTER : DONE;
                end
            end
            FILTER:  nextState = CLEAR;
            DONE:    nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            pass      <= COARSE;
            window    <= '0;
            findTail  <= 2'b00;
            peakTime  <= '0;
            peakCount <= '0;
        end else begin
            state    <= nextState;
            findTail <= {findTail[0], (state == FIND) && sweepLast};
            if ((state == IDLE) && start) begin
                pass <= COARSE;
            end
            if (state == FILTER) begin
                window <= peakIn.bin; // coarse peak becomes the fine window
                pass   <= FINE;
            end
            // finder result is stable on the last FIND cycle
            if ((state == FIND) && findTail[1] && (pass == FINE)) begin
                peakTime  <= {window, peakIn.bin};
                peakCount <= peakIn.count;
            end
        end
    end

endmodule

// File: sifhTop.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module sifhTop (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  sifhPkg::tdcHitT        hit,
    output logic                   acquire,
    output logic                   busy,
    output logic                   done,
    output logic [`SIFH_NP-1:0]    peakTime,
    output logic [`SIFH_CNT_W-1:0] peakCount
);
    import sifhPkg::*;

    seqStateT               state;
    passT                   pass;
    logic [`SIFH_NB-1:0]    window;
    logic [`SIFH_NB-1:0]    index;
    logic                   sweepEn;
    logic                   countClear;
    logic                   sweepLast;
    logic                   hitsDone;
    logic                   hitAccept;
    logic                   pipeEmpty;
    logic                   findSweep;
    peakT                   peak;
    ramWrT                  accWr;
    ramWrT                  clearWr;
    ramWrT                  ramWr;
    ramRdT                  accRd;
    ramRdT                  pfRd;
    ramRdT                  ramRd;
    logic [`SIFH_CNT_W-1:0] rdData;

    assign findSweep = sweepEn && (state == FIND); // keep finder off during clear
    assign clearWr   = '{en: 1'b1, addr: index, data: '0};

    // ram port ownership follows the sequencer state
    always_comb begin
        ramWr = '0;
        ramRd = '0;
        case (state)
            CLEAR: ramWr = clearWr;
            BUILD: begin
                ramWr = accWr;
                ramRd = accRd;
            end
            FIND:    ramRd = pfRd;
            default: ramWr = '0;
        endcase
    end

    sifhSequencer u_seq (
        .clk(clk), .res(res), .start(start),
        .sweepLast(sweepLast), .hitsDone(hitsDone), .pipeEmpty(pipeEmpty),
        .peakIn(peak), .state(state), .pass(pass), .window(window),
        .sweepEn(sweepEn), .countClear(countClear),
        .acquire(acquire), .busy(busy), .done(done),
        .peakTime(peakTime), .peakCount(peakCount)
    );

    binCounter u_cnt (
        .clk(clk), .res(res), .countClear(countClear), .sweepEn(sweepEn),
        .hitAccept(hitAccept), .index(index), .sweepLast(sweepLast), .hitsDone(hitsDone)
    );

    histAccumulator u_acc (
        .clk(clk), .res(res), .enable(acquire), .pass(pass), .window(window),
        .hit(hit), .rdData(rdData), .rd(accRd), .wr(accWr),
        .hitAccept(hitAccept), .pipeEmpty(pipeEmpty)
    );

    histRam u_ram (.clk(clk), .wr(ramWr), .rd(ramRd), .rdData(rdData));

    peakFinder u_peak (
        .clk(clk), .res(res), .clear(countClear), .sweepEn(findSweep),
        .index(index), .rdData(rdData), .rd(pfRd), .peak(peak)
    );

endmodule

// File: sifh_chk.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module sifh_chk (
    input logic               clk,
    input logic               res,
    input sifhPkg::seqStateT  state,
    input logic               done,
    input logic               acquire
);
    import sifhPkg::*;

    int clearLen; // cycles spent in the current clear sweep
    int failCount;

    initial failCount = 0;

    always @(posedge clk or negedge res) begin
        if (!res) begin
            clearLen <= 0;
        end else if (state == CLEAR) begin
            clearLen <= clearLen + 1;
        end else begin
            clearLen <= 0;
        end
    end

    assert property (@(posedge clk) disable iff (!res) done |=> !done)
        else begin
            failCount++;
            $error("done pulse lasted more than one cycle");
        end

    // one unbroken window that opens on the first BUILD cycle
    assert property (@(posedge clk) disable iff (!res)
        acquire |-> (state == BUILD) && ($past(acquire) || ($past(state) != BUILD)))
        else begin
            failCount++;
            $error("acquire high outside BUILD or raised again within BUILD");
        end

    assert property (@(posedge clk) disable iff (!res)
        ((clearLen != 0) && (state != CLEAR)) |-> (clearLen == `SIFH_BINS))
        else begin
            failCount++;
            $error("clear sweep did not last one cycle per bin");
        end

endmodule

// File: sifhMonitor.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module sifhMonitor (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start,
    input  logic                   busy,
    input  logic                   acquire,
    input  logic                   done,
    input  sifhPkg::tdcHitT        hit,
    input  logic [`SIFH_NP-1:0]    peakTime,
    input  logic [`SIFH_CNT_W-1:0] peakCount,
    output int                     errors,
    output int                     checks
);
    logic [`SIFH_NP-1:0] stamps [2*`SIFH_HITS];
    int                  nHits;

    // histogram with saturation, then lowest bin among the fullest
    task automatic findPeak(input int first, input logic useWindow,
                            input logic [`SIFH_NB-1:0] window,
                            output logic [`SIFH_NB-1:0] bin, output int cnt);
        int hist [`SIFH_BINS];
        logic [`SIFH_NB-1:0] coarse;
        logic [`SIFH_NB-1:0] b;
        foreach (hist[i]) hist[i] = 0;
        for (int i = first; i < first + `SIFH_HITS; i++) begin
            coarse = stamps[i][`SIFH_NP-1 -: `SIFH_NB];
            b = useWindow ? stamps[i][`SIFH_NB-1:0] : coarse;
            if ((!useWindow || coarse == window) && hist[b] < `SIFH_CNT_MAX) begin
                hist[b]++;
            end
        end
        bin = '0;
        cnt = 0;
        for (int i = 0; i < `SIFH_BINS; i++) begin
            if (hist[i] > cnt) begin
                cnt = hist[i];
                bin = `SIFH_NB'(i);
            end
        end
    endtask

    always @(posedge clk) begin
        logic [`SIFH_NB-1:0] window;
        logic [`SIFH_NB-1:0] fineBin;
        int cnt;
        if (res) begin
            if (start && !busy) begin
                nHits = 0;
            end else if (acquire && hit.valid) begin
                if (nHits < 2*`SIFH_HITS) stamps[nHits] = hit.stamp;
                nHits++;
            end
            if (done) begin
                checks++;
                if (nHits != 2*`SIFH_HITS) begin
                    errors++;
                    $display("monitor saw %0d accepted hits instead of %0d at %0t",
                             nHits, 2*`SIFH_HITS, $time);
                end else begin
                    findPeak(0, 1'b0, '0, window, cnt);
                    findPeak(`SIFH_HITS, 1'b1, window, fineBin, cnt);
                    if (peakTime !== {window, fineBin}) begin
                        errors++;
                        $display("[FAIL] %0t peakTime got %h expected %h",
                                 $time, peakTime, {window, fineBin});
                    end
                    if (peakCount !== `SIFH_CNT_W'(cnt)) begin
                        errors++;
                        $display("[FAIL] %0t peakCount got %0d expected %0d",
                                 $time, peakCount, cnt);
                    end
                end
            end
        end
    end

    initial begin
        errors = 0;
        checks = 0;
        nHits  = 0;
    end

endmodule

// File: tbSifh.sv
`timescale 1ns/1ps
`include "sifh_settings.svh"

module tbSifh;
    import sifhPkg::*;

    localparam int rows = 5;
    localparam int rowCycles = 2 * (2*`SIFH_HITS + 2*`SIFH_BINS + 16);
    localparam longint limitNs = 64'(4 * (32 + rows*rowCycles) * 20); // margin of four

    typedef struct packed {
        logic [`SIFH_NP-1:0]    dom;      // dominant stamp
        int                     rep;
        logic [`SIFH_NP-1:0]    sec;      // second stamp in the same window
        int                     secRep;
        logic [`SIFH_NB-1:0]    noiseBin; // coarse bin of the noise hits
        logic                   idle;     // gaps and ignored hits
        logic [`SIFH_NP-1:0]    expTime;
        logic [`SIFH_CNT_W-1:0] expCount;
    } rowT;

    logic                   clk;
    logic                   res;
    logic                   start;
    tdcHitT                 hit;
    logic                   acquire;
    logic                   busy;
    logic                   done;
    logic [`SIFH_NP-1:0]    peakTime;
    logic [`SIFH_CNT_W-1:0] peakCount;
    int                     errors;
    int                     monErrors;
    int                     monChecks;
    logic [31:0]            lfsr;
    rowT                    tbl [rows];

    sifhTop u_dut (.clk(clk), .res(res), .start(start), .hit(hit), .acquire(acquire),
        .busy(busy), .done(done), .peakTime(peakTime), .peakCount(peakCount));

    sifhMonitor u_mon (.clk(clk), .res(res), .start(start), .busy(busy),
        .acquire(acquire), .done(done), .hit(hit), .peakTime(peakTime),
        .peakCount(peakCount), .errors(monErrors), .checks(monChecks));

    bind sifhSequencer sifh_chk u_chk (.clk(clk), .res(res), .state(state),
        .done(done), .acquire(acquire));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) s = s ^ 32'h80200003;
        return s;
    endfunction

    function automatic logic [`SIFH_NP-1:0] pickStamp(input rowT r, input int idx);
        logic [`SIFH_NB-1:0] fine;
        if (idx < r.rep) return r.dom;
        if (idx < r.rep + r.secRep) return r.sec;
        for (int b = 0; b < `SIFH_NB; b++) begin
            lfsr = lfsrStep(lfsr); // one step per bit
            fine[b] = lfsr[0];
        end
        return {r.noiseBin, fine};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic runRow(input rowT r);
        int   idx;
        logic gap;
        idx = 0;
        gap = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkValue("busy", 32'(busy), 32'd1);
        while (!done) begin
            if (acquire) begin
                if (r.idle && gap) begin
                    hit = '0;
                end else begin
                    hit = tdcHitT'{valid: 1'b1, stamp: pickStamp(r, idx)};
                    idx++;
                end
                gap = r.idle && !gap;
            end else begin
                idx = 0;
                gap = 1'b0;
                // would move the peak if it were counted
                hit = r.idle ? tdcHitT'{valid: 1'b1, stamp: {r.dom[`SIFH_NP-1 -: `SIFH_NB],
                                                             ~r.dom[`SIFH_NB-1:0]}} : '0;
            end
            @(negedge clk);
        end
        hit = '0;
        checkValue("peakTime", 32'(peakTime), 32'(r.expTime));
        checkValue("peakCount", 32'(peakCount), 32'(r.expCount));
        @(negedge clk);
        checkValue("done", 32'(done), 32'd0);
        checkValue("busy", 32'(busy), 32'd0);
    endtask

    initial begin
        res    = 1'b0;
        start  = 1'b0;
        hit    = '0;
        errors = 0;
        lfsr   = 32'hd43eb850;
        tbl[0] = '{10'h1A7, 40, 10'h000, 0, 5'd3, 1'b0, 10'h1A7, 6'd40};
        tbl[1] = '{10'h3C2, 64, 10'h000, 0, 5'd0, 1'b0, 10'h3C2, 6'd63}; // saturates
        tbl[2] = '{10'h2A5, 20, 10'h2A3, 20, 5'd3, 1'b1, 10'h2A3, 6'd20}; // tie
        tbl[3] = '{10'h045, 36, 10'h000, 0, 5'd30, 1'b1, 10'h045, 6'd36};
        tbl[4] = '{10'h3FF, 33, 10'h3E0, 10, 5'd1, 1'b0, 10'h3FF, 6'd33};
        repeat (16) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        checkValue("acquire", 32'(acquire), 32'd0);
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("done", 32'(done), 32'd0);
        for (int i = 0; i < rows; i++) begin
            runRow(tbl[i]);
        end
        repeat (2) @(negedge clk);
        if (monChecks != rows) begin
            errors++;
            $display("monitor compared %0d results instead of %0d", monChecks, rows);
        end
        $display("errors: testbench %0d, monitor %0d, assertions %0d",
                 errors, monErrors, u_dut.u_seq.u_chk.failCount);
        if (errors == 0 && monErrors == 0 && u_dut.u_seq.u_chk.failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(limitNs);
        $display("timeout, no done pulse within %0d ns", limitNs);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
sifhPkg.sv
binCounter.sv
histRam.sv
histAccumulator.sv
peakFinder.sv
sifhSequencer.sv
sifhTop.sv
sifh_chk.sv
sifhMonitor.sv
tbSifh.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tbSifh
FLIST      ?= vlog.f
OBJDIR     ?= obj_dir
VFLAGS     ?= --timing --assert
RUNFLAGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FLIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
